//--- project.f
rtl/merge_pkg.sv
rtl/sync_fifo.sv
rtl/merge_datapath.sv
rtl/merge_control.sv
rtl/run_merger.sv
test/run_merger_checker.sv
test/run_merger_monitor.sv
test/tb_run_merger.sv

//--- rtl/merge_control.sv
`timescale 1ns/1ps

module merge_control (
   input  logic                   i_clk,
   input  logic                   i_arst_n,
   input  merge_pkg::head_flags_t i_flags,
   input  logic                   i_out_full,
   input  logic                   i_end_of_data,
   output logic                   o_pop_a,
   output logic                   o_pop_b,
   output logic                   o_out_push,
   output logic                   o_sel_a,
   output logic                   o_emit_term,
   output logic                   o_run_toggle,
   output logic                   o_done
);

   import merge_pkg::*;

   merge_state_e state;
   merge_state_e state_nxt;
   logic         need_a;
   logic         need_b;
   logic         stall;
   logic         both_term;
   logic         finish;

   assign both_term = i_flags.a_term & i_flags.b_term;

   // between runs with no input left and the source closed, the merge is over
   assign finish = (state == ST_TOGGLE) & i_end_of_data & i_flags.a_empty & i_flags.b_empty;

   // which heads the current state has to look at before it may move
   always_comb begin
      need_a = 1'b0;
      need_b = 1'b0;
      case (state)
         ST_TOGGLE, ST_NOMINAL: begin
            need_a = 1'b1;
            need_b = 1'b1;
         end
         // in done-A the A head is a parked terminator, only B matters
         ST_DONE_A: need_b = 1'b1;
         ST_DONE_B: need_a = 1'b1;
         default: begin
            need_a = 1'b0;
            need_b = 1'b0;
         end
      endcase
   end

   // a stall freezes state, pops and pushes for this cycle
   assign stall = (state == ST_FINISHED) | i_out_full
                | (need_a & i_flags.a_empty) | (need_b & i_flags.b_empty);

   always_comb begin
      state_nxt    = state;
      o_pop_a      = 1'b0;
      o_pop_b      = 1'b0;
      o_out_push   = 1'b0;
      o_sel_a      = 1'b0;
      o_emit_term  = 1'b0;
      o_run_toggle = 1'b0;
      case (state)
         ST_TOGGLE, ST_NOMINAL: begin
            if (both_term) begin
               // the closing zero is only written from toggle, nominal falls back there first
               o_emit_term = (state == ST_TOGGLE);
               if (!stall) begin
                  o_pop_a      = o_emit_term;
                  o_pop_b      = o_emit_term;
                  o_out_push   = o_emit_term;
                  o_run_toggle = o_emit_term;
                  state_nxt    = ST_TOGGLE;
               end
            end else if (i_flags.a_term) begin
               // A's run is over, the current B word goes out and B is drained
               if (!stall) begin
                  o_pop_b    = 1'b1;
                  o_out_push = 1'b1;
                  state_nxt  = ST_DONE_A;
               end
            end else if (i_flags.b_term) begin
               o_sel_a = 1'b1;
               if (!stall) begin
                  o_pop_a    = 1'b1;
                  o_out_push = 1'b1;
                  state_nxt  = ST_DONE_B;
               end
            end else begin
               // both runs active, the smaller head wins
               o_sel_a = i_flags.a_lte_b;
               if (!stall) begin
                  o_pop_a    = i_flags.a_lte_b;
                  o_pop_b    = ~i_flags.a_lte_b;
                  o_out_push = 1'b1;
                  state_nxt  = ST_NOMINAL;
               end
            end
         end
         ST_DONE_A: begin
            // once B also shows its terminator both runs are closed together in toggle
            if (!stall) begin
               o_pop_b    = ~i_flags.b_term;
               o_out_push = ~i_flags.b_term;
               state_nxt  = i_flags.b_term ? ST_TOGGLE : ST_DONE_A;
            end
         end
         ST_DONE_B: begin
            o_sel_a = 1'b1;
            if (!stall) begin
               o_pop_a    = ~i_flags.a_term;
               o_out_push = ~i_flags.a_term;
               state_nxt  = i_flags.a_term ? ST_TOGGLE : ST_DONE_B;
            end
         end
         default: state_nxt = ST_FINISHED;
      endcase
      // finished is sticky until the next reset
      if (finish) begin
         state_nxt = ST_FINISHED;
      end
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state <= ST_TOGGLE;
      end else begin
         state <= state_nxt;
      end
   end

   assign o_done = (state == ST_FINISHED);

endmodule

//--- rtl/merge_datapath.sv
`timescale 1ns/1ps

module merge_datapath (
   input  logic                   i_clk,
   input  logic                   i_arst_n,
   input  merge_pkg::key_word_t   i_a_head,
   input  merge_pkg::key_word_t   i_b_head,
   input  logic                   i_a_empty,
   input  logic                   i_b_empty,
   input  logic                   i_sel_a,
   input  logic                   i_emit_term,
   input  logic                   i_run_toggle,
   output merge_pkg::head_flags_t o_flags,
   output merge_pkg::out_word_t   o_out_word
);

   import merge_pkg::*;

   logic             bank;
   logic [KEY_W-1:0] sel_key;

   // a head only counts as a terminator when its queue really holds a word,
   // the array behind an empty queue still shows a stale entry
   assign o_flags.a_term = ~i_a_empty & (i_a_head.key == {KEY_W{1'b0}});
   assign o_flags.b_term = ~i_b_empty & (i_b_head.key == {KEY_W{1'b0}});

   // ties resolve towards A so that equal keys leave A's stream first
   assign o_flags.a_lte_b = (i_a_head.key <= i_b_head.key);

   // the control needs the empty flags to decide when to stall
   assign o_flags.a_empty = i_a_empty;
   assign o_flags.b_empty = i_b_empty;

   // the selected head is copied to the output unchanged
   assign sel_key = i_sel_a ? i_a_head.key : i_b_head.key;

   // a terminator is written as an explicit zero key whichever head is selected
   assign o_out_word.key  = i_emit_term ? {KEY_W{1'b0}} : sel_key;
   assign o_out_word.bank = bank;

   // bank of the run being written, it flips on the edge that writes the
   // closing zero word so the terminator still carries the old bank
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         bank <= 1'b0;
      end else if (i_run_toggle) begin
         bank <= ~bank;
      end
   end

endmodule

//--- rtl/merge_pkg.sv
package merge_pkg;

   // keys are KEY_W bits wide and a zero key marks the end of a run
   localparam int KEY_W = 16;

   // entries held by each of the three queues
   localparam int FIFO_DEPTH = 8;

   // pointer and occupancy widths of a queue whose count must reach FIFO_DEPTH itself
   localparam int PTR_W = $clog2(FIFO_DEPTH);
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   // run-merge control states
   typedef enum logic [2:0] {
      ST_NOMINAL  = 3'b000,
      ST_TOGGLE   = 3'b001,
      ST_DONE_A   = 3'b010,
      ST_DONE_B   = 3'b011,
      ST_FINISHED = 3'b100
   } merge_state_e;

   // one word of an input stream
   typedef struct packed {
      logic [KEY_W-1:0] key;
   } key_word_t;

   // one word of the merged stream whose bank alternates from run to run
   typedef struct packed {
      logic [KEY_W-1:0] key;
      logic             bank;
   } out_word_t;

   // head status handed from the datapath to the control
   typedef struct packed {
      logic a_term;
      logic b_term;
      logic a_lte_b;
      logic a_empty;
      logic b_empty;
   } head_flags_t;

endpackage

//--- rtl/run_merger.sv
`timescale 1ns/1ps

module run_merger (
   input  logic                 i_clk,
   input  logic                 i_arst_n,
   input  logic                 i_a_push,
   input  merge_pkg::key_word_t i_a_word,
   input  logic                 i_b_push,
   input  merge_pkg::key_word_t i_b_word,
   input  logic                 i_out_pop,
   input  logic                 i_end_of_data,
   output logic                 o_a_full,
   output logic                 o_b_full,
   output merge_pkg::out_word_t o_out_word,
   output logic                 o_out_empty,
   output logic                 o_done
);

   import merge_pkg::*;

   key_word_t   a_head;
   key_word_t   b_head;
   logic        a_empty;
   logic        b_empty;
   logic        out_full;
   head_flags_t flags;
   out_word_t   merged_word;
   logic        pop_a;
   logic        pop_b;
   logic        out_push;
   logic        sel_a;
   logic        emit_term;
   logic        run_toggle;

   // input queue for stream A
   sync_fifo #(.payload_t(key_word_t)) u_fifo_a (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_push   (i_a_push),
      .i_data   (i_a_word),
      .i_pop    (pop_a),
      .o_head   (a_head),
      .o_empty  (a_empty),
      .o_full   (o_a_full)
   );

   // input queue for stream B
   sync_fifo #(.payload_t(key_word_t)) u_fifo_b (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_push   (i_b_push),
      .i_data   (i_b_word),
      .i_pop    (pop_b),
      .o_head   (b_head),
      .o_empty  (b_empty),
      .o_full   (o_b_full)
   );

   // merged output, its full flag is the only source of back-pressure
   sync_fifo #(.payload_t(out_word_t)) u_fifo_out (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_push   (out_push),
      .i_data   (merged_word),
      .i_pop    (i_out_pop),
      .o_head   (o_out_word),
      .o_empty  (o_out_empty),
      .o_full   (out_full)
   );

   merge_datapath u_datapath (
      .i_clk        (i_clk),
      .i_arst_n     (i_arst_n),
      .i_a_head     (a_head),
      .i_b_head     (b_head),
      .i_a_empty    (a_empty),
      .i_b_empty    (b_empty),
      .i_sel_a      (sel_a),
      .i_emit_term  (emit_term),
      .i_run_toggle (run_toggle),
      .o_flags      (flags),
      .o_out_word   (merged_word)
   );

   merge_control u_control (
      .i_clk         (i_clk),
      .i_arst_n      (i_arst_n),
      .i_flags       (flags),
      .i_out_full    (out_full),
      .i_end_of_data (i_end_of_data),
      .o_pop_a       (pop_a),
      .o_pop_b       (pop_b),
      .o_out_push    (out_push),
      .o_sel_a       (sel_a),
      .o_emit_term   (emit_term),
      .o_run_toggle  (run_toggle),
      .o_done        (o_done)
   );

endmodule

//--- rtl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
   parameter type payload_t = merge_pkg::key_word_t
) (
   input  logic     i_clk,
   input  logic     i_arst_n,
   input  logic     i_push,
   input  payload_t i_data,
   input  logic     i_pop,
   output payload_t o_head,
   output logic     o_empty,
   output logic     o_full
);

   import merge_pkg::*;

   payload_t         mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   // a push into a full queue and a pop from an empty one are both dropped
   assign do_push = i_push & ~o_full;
   assign do_pop  = i_pop & ~o_empty;

   assign o_empty = (count == '0);
   assign o_full  = (count == CNT_W'(FIFO_DEPTH));

   // the head is read straight from the array for first-word fall-through
   assign o_head = mem[rd_ptr];

   // the pointers and the count alone mark which entries hold valid words
   always_ff @(posedge i_clk) begin
      if (do_push) begin
         mem[wr_ptr] <= i_data;
      end
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // pointers wrap at the last entry so that any depth works
         if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // push and pop together leave the occupancy where it was
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the run merger testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_run_merger -f project.f -Mdir obj_dir -o sim_run_merger
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

# raise the error limit so that every failed assertion is counted
output=$(./obj_dir/sim_run_merger +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
   exit 0
fi
exit 1

//--- test/run_merger_checker.sv
`timescale 1ns/1ps

module run_merger_checker (
   input logic                    i_clk,
   input logic                    i_arst_n,
   input logic                    i_out_push,
   input logic                    i_out_full,
   input merge_pkg::merge_state_e i_state,
   input logic                    i_done
);

   import merge_pkg::*;

   // running count of failed assertions
   int assert_fails = 0;

   // the control stalls instead of pushing into a full output queue
   a_no_push_when_full: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      !(i_out_push && i_out_full))
      else begin
         assert_fails++;
         $error("output push while the output queue is full");
      end

   a_state_legal: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      i_state inside {ST_NOMINAL, ST_TOGGLE, ST_DONE_A, ST_DONE_B, ST_FINISHED})
      else begin
         assert_fails++;
         $error("control state holds an illegal encoding");
      end

   // only reset takes o_done down once finished is reached
   a_done_sticky: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      i_done |=> i_done)
      else begin
         assert_fails++;
         $error("o_done fell without a reset");
      end

endmodule

bind run_merger run_merger_checker u_checker (
   .i_clk      (i_clk),
   .i_arst_n   (i_arst_n),
   .i_out_push (out_push),
   .i_out_full (out_full),
   .i_state    (u_control.state),
   .i_done     (o_done)
);

//--- test/run_merger_monitor.sv
`timescale 1ns/1ps

module run_merger_monitor (
   input  logic                 i_clk,
   input  logic                 i_arst_n,
   input  logic                 i_load,
   input  merge_pkg::out_word_t i_load_word,
   input  logic                 i_pop,
   input  merge_pkg::out_word_t i_out_word,
   input  logic                 i_out_empty,
   output int                   o_errors,
   output int                   o_checked,
   output int                   o_pending
);

   import merge_pkg::*;

   out_word_t        expected[$];
   out_word_t        exp_word;
   logic [KEY_W-1:0] last_key;

   initial begin
      o_errors  = 0;
      o_checked = 0;
      o_pending = 0;
      last_key  = '0;
   end

   // the queue takes a pop at the same edge, so the head seen here is the word leaving
   always @(posedge i_clk) begin
      if (i_load) begin
         expected.push_back(i_load_word);
      end
      if (i_arst_n && i_pop && !i_out_empty) begin
         if (expected.size() == 0) begin
            $display("[ERROR] %0t: extra word key %0d bank %0d after the last expected one",
                     $time, i_out_word.key, i_out_word.bank);
            o_errors++;
         end else begin
            exp_word = expected.pop_front();
            if (i_out_word !== exp_word) begin
               $display("[ERROR] %0t: word %0d is key %0d bank %0d, expected key %0d bank %0d",
                        $time, o_checked, i_out_word.key, i_out_word.bank,
                        exp_word.key, exp_word.bank);
               o_errors++;
            end
         end
         // independent of the expected list, keys inside one run never go down
         if (i_out_word.key != '0 && i_out_word.key < last_key) begin
            $display("[ERROR] %0t: key %0d follows %0d inside one run",
                     $time, i_out_word.key, last_key);
            o_errors++;
         end
         last_key = i_out_word.key;
         o_checked++;
      end
      o_pending = expected.size();
   end

endmodule

//--- test/tb_run_merger.sv
`timescale 1ns/1ps

module tb_run_merger;

   import merge_pkg::*;

   localparam int NUM_PAIRS = 24;
   localparam int TIMEOUT   = 4000;

   logic      clk;
   logic      arst_n;
   logic      a_push;
   key_word_t a_word;
   logic      b_push;
   key_word_t b_word;
   logic      out_pop;
   logic      end_of_data;
   logic      a_full;
   logic      b_full;
   out_word_t out_word;
   logic      out_empty;
   logic      done;
   logic      load;
   out_word_t load_word;
   int        mon_errors;
   int        mon_checked;
   int        mon_pending;
   integer    seed;
   int        other_errors;
   int        total_errors;
   int        cycles;
   int        full_cycles;
   int        ia;
   int        ib;
   key_word_t a_stream[$];
   key_word_t b_stream[$];
   out_word_t exp_words[$];

   run_merger i_run_merger (
      .i_clk         (clk),
      .i_arst_n      (arst_n),
      .i_a_push      (a_push),
      .i_a_word      (a_word),
      .i_b_push      (b_push),
      .i_b_word      (b_word),
      .i_out_pop     (out_pop),
      .i_end_of_data (end_of_data),
      .o_a_full      (a_full),
      .o_b_full      (b_full),
      .o_out_word    (out_word),
      .o_out_empty   (out_empty),
      .o_done        (done)
   );

   run_merger_monitor u_monitor (
      .i_clk       (clk),
      .i_arst_n    (arst_n),
      .i_load      (load),
      .i_load_word (load_word),
      .i_pop       (out_pop),
      .i_out_word  (out_word),
      .i_out_empty (out_empty),
      .o_errors    (mon_errors),
      .o_checked   (mon_checked),
      .o_pending   (mon_pending)
   );

   // 4 ns period
   always #2 clk = ~clk;

   // cycles in which the output queue was full and held the merge back
   always @(posedge clk) begin
      if (arst_n && i_run_merger.out_full) begin
         full_cycles++;
      end
   end

   // appends one run of nondecreasing nonzero keys and its closing zero word
   task automatic add_run(input bit to_b, input int len);
      int        key;
      key_word_t w;
      key = ($random(seed) & 32'h1f) + 1;
      for (int n = 0; n <= len; n++) begin
         // the last word of the run is the zero terminator
         w.key = (n == len) ? '0 : key[KEY_W-1:0];
         if (to_b) begin
            b_stream.push_back(w);
         end else begin
            a_stream.push_back(w);
         end
         key = key + ($random(seed) & 32'h3);
      end
   endtask

   // expected merged stream with ties taken from A and bank set to the run number mod 2
   function automatic void merge_runs();
      int        pa;
      int        pb;
      out_word_t w;
      pa = 0;
      pb = 0;
      for (int k = 0; k < NUM_PAIRS; k++) begin
         w.bank = k[0];
         while (a_stream[pa].key != '0 || b_stream[pb].key != '0) begin
            if (a_stream[pa].key == '0 ||
                (b_stream[pb].key != '0 && b_stream[pb].key < a_stream[pa].key)) begin
               w.key = b_stream[pb].key;
               pb++;
            end else begin
               w.key = a_stream[pa].key;
               pa++;
            end
            exp_words.push_back(w);
         end
         w.key = '0;
         exp_words.push_back(w);
         // step over both terminators
         pa++;
         pb++;
      end
   endfunction

   // one clock of stimulus where every push is followed by an idle cycle so that
   // the sampled full flag already counts it
   task automatic drive_cycle();
      a_push <= 1'b0;
      b_push <= 1'b0;
      if (!a_push && !a_full && ia < a_stream.size() && ($random(seed) & 1)) begin
         a_push <= 1'b1;
         a_word <= a_stream[ia];
         ia++;
      end
      if (!b_push && !b_full && ib < b_stream.size() && ($random(seed) & 1)) begin
         b_push <= 1'b1;
         b_word <= b_stream[ib];
         ib++;
      end
      // popping slower than the inputs fill lets the output queue run full
      out_pop <= (($random(seed) & 3) == 0);
   endtask

   initial begin
      seed         = 32'h3ec3_d5ae;
      clk          = 1'b0;
      arst_n       = 1'b0;
      a_push       = 1'b0;
      a_word       = '0;
      b_push       = 1'b0;
      b_word       = '0;
      out_pop      = 1'b0;
      end_of_data  = 1'b0;
      load         = 1'b0;
      load_word    = '0;
      other_errors = 0;
      full_cycles  = 0;
      // directed pairs come first with both runs empty, then A empty, then B empty
      add_run(1'b0, 0);
      add_run(1'b1, 0);
      add_run(1'b0, 0);
      add_run(1'b1, 4);
      add_run(1'b0, 5);
      add_run(1'b1, 0);
      for (int k = 3; k < NUM_PAIRS; k++) begin
         add_run(1'b0, ($random(seed) & 32'h7fffffff) % 7);
         add_run(1'b1, ($random(seed) & 32'h7fffffff) % 7);
      end
      merge_runs();
      repeat (4) @(posedge clk);
      arst_n <= 1'b1;
      @(posedge clk);
      if (done || !out_empty) begin
         $display("[ERROR] %0t: after reset o_done=%0b o_out_empty=%0b", $time, done, out_empty);
         other_errors++;
      end
      // the expected stream goes to the monitor one word per clock
      foreach (exp_words[i]) begin
         load      <= 1'b1;
         load_word <= exp_words[i];
         @(posedge clk);
      end
      load   <= 1'b0;
      ia     = 0;
      ib     = 0;
      cycles = 0;
      while ((ia < a_stream.size() || ib < b_stream.size()) && cycles < TIMEOUT) begin
         @(posedge clk);
         drive_cycle();
         cycles++;
      end
      if (cycles >= TIMEOUT) begin
         $display("timeout: the input streams were not accepted within %0d cycles", TIMEOUT);
         other_errors++;
      end
      // the last push is taken on this edge
      @(posedge clk);
      a_push      <= 1'b0;
      b_push      <= 1'b0;
      end_of_data <= 1'b1;
      cycles = 0;
      while (!done && cycles < TIMEOUT) begin
         @(posedge clk);
         out_pop <= (($random(seed) & 3) == 0);
         cycles++;
      end
      if (!done) begin
         $display("timeout: o_done did not rise within %0d cycles", TIMEOUT);
         other_errors++;
      end
      cycles = 0;
      while (!out_empty && cycles < TIMEOUT) begin
         @(posedge clk);
         out_pop <= 1'b1;
         cycles++;
      end
      if (!out_empty) begin
         $display("timeout: the output queue did not drain within %0d cycles", TIMEOUT);
         other_errors++;
      end
      // nothing more may appear while popping goes on and o_done has to stay high
      repeat (20) begin
         @(posedge clk);
         if (!out_empty || !done) begin
            $display("[ERROR] %0t: after the end o_out_empty=%0b o_done=%0b",
                     $time, out_empty, done);
            other_errors++;
         end
      end
      out_pop <= 1'b0;
      if (mon_pending != 0) begin
         $display("[ERROR] %0t: %0d expected words never came out", $time, mon_pending);
         other_errors++;
      end
      if (full_cycles == 0) begin
         $display("the output queue never ran full so back-pressure was not exercised");
         other_errors++;
      end
      total_errors = mon_errors + other_errors + i_run_merger.u_checker.assert_fails;
      $display("checked %0d words, errors: %0d compare, %0d assertion, %0d other",
               mon_checked, mon_errors, i_run_merger.u_checker.assert_fails, other_errors);
      if (total_errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule
